/* mem_arb_sys.f */
hdl/mem_cfg_pkg.sv
hdl/mem_if_pkg.sv
hdl/req_queue.sv
hdl/l2_block_store.sv
hdl/memory_arbiter.sv
hdl/mem_arb_top.sv
dv/mem_arb_tb.sv

/* dv/mem_arb_tb.sv */
// Memory subsystem testbench
// Drives both ports, models the L2 store and checks every response in order
`timescale 1ns/1ps
`default_nettype none

module mem_arb_tb;

  import mem_cfg_pkg::*;
  import mem_if_pkg::*;

  localparam int unsigned BYTES      = BLK_SIZE / 8;
  localparam int unsigned BOFF       = $clog2(BYTES);
  localparam int unsigned TOTAL_REQS = 72;  // Sum over all tests below
  localparam int unsigned MAX_CYCLES = TOTAL_REQS * (L2_LATENCY + 4) * 2 + 200;

  logic      clk_i;
  logic      rst_ni;
  ilow_req_t icache_req;
  logic      icache_ready;
  ilow_res_t icache_res;
  dlow_req_t dcache_req;
  logic      dcache_ready;
  dlow_res_t dcache_res;

  logic [BLK_SIZE-1:0] ref_mem [L2_BLOCKS];  // Reference block store
  logic [ADDR_W-1:0]   addr_pool [4];
  ilow_req_t           exp_i_q [$];           // Accepted and not yet answered
  dlow_req_t           exp_d_q [$];
  int                  order_q [$];           // Port per response with 0 for fetch and 1 for data
  string               test_name;
  int                  errors, test_err0, n_tests, n_pass, cycles;
  int                  acc_d, res_d;
  bit                  stalled;

  mem_arb_top #(
    .L2_BLOCKS(L2_BLOCKS), .L2_LATENCY(L2_LATENCY), .QUEUE_DEPTH(QUEUE_DEPTH)
  ) i_dut (
    .clk_i, .rst_ni,
    .icache_req_i  (icache_req),
    .icache_ready_o(icache_ready),
    .icache_res_o  (icache_res),
    .dcache_req_i  (dcache_req),
    .dcache_ready_o(dcache_ready),
    .dcache_res_o  (dcache_res)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // Responses are single pulses and never overlap
  ires_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    icache_res.valid |=> !icache_res.valid)
    else begin $display("Fetch response valid held past one cycle"); errors++; end
  dres_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    dcache_res.valid |=> !dcache_res.valid)
    else begin $display("Data response valid held past one cycle"); errors++; end
  res_excl: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(icache_res.valid && dcache_res.valid))
    else begin $display("Fetch and data responses valid together"); errors++; end

  function automatic int blk_index(input logic [ADDR_W-1:0] a);
    return int'(a >> BOFF) % L2_BLOCKS;
  endfunction

  function automatic int size_bytes(input rw_size_e s);
    case (s)
      BYTE:    return 1;
      HALF:    return 2;
      WORD:    return 4;
      default: return BYTES;  // Whole block
    endcase
  endfunction

  // Write merge over the lanes from the offset up by the access size
  function automatic logic [BLK_SIZE-1:0] merge_blk(input logic [BLK_SIZE-1:0] old,
                                                    input dlow_req_t r);
    logic [BLK_SIZE-1:0] blk;
    int lo, n;
    blk = old;
    n   = size_bytes(r.rw_size);
    lo  = (n == BYTES) ? 0 : int'(r.addr % BYTES);
    for (int i = lo; i < lo + n; i++) blk[i*8 +: 8] = r.data[i*8 +: 8];
    return blk;
  endfunction

  function automatic dlow_req_t rand_dreq(input logic rw, input logic [ADDR_W-1:0] addr,
                                          input int smin, input int smax);
    dlow_req_t r;
    int n;
    r.valid   = 1'b1;
    r.rw      = rw;
    r.rw_size = rw_size_e'(2'($urandom_range(smax, smin)));
    r.data    = {$urandom, $urandom, $urandom, $urandom};
    r.id      = ID_W'($urandom);
    n         = size_bytes(r.rw_size);
    r.addr    = addr - ADDR_W'(addr % n);  // Natural alignment
    return r;
  endfunction

  task automatic check_val(input string what, input logic [BLK_SIZE-1:0] exp,
                           input logic [BLK_SIZE-1:0] act);
    assert (act === exp) else begin
      $display("CHECK FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
      errors++;
    end
  endtask

  // Caller sits at a falling edge and returns at the one after acceptance
  task automatic send_fetch(input logic [ADDR_W-1:0] addr, input logic [ID_W-1:0] id);
    icache_req.valid = 1'b1;
    icache_req.addr  = addr;
    icache_req.id    = id;
    while (!icache_ready) @(negedge clk_i);
    exp_i_q.push_back(icache_req);
    @(negedge clk_i);
    icache_req.valid = 1'b0;
  endtask

  task automatic send_data(input dlow_req_t r);
    dcache_req = r;
    while (!dcache_ready) begin
      stalled = 1'b1;  // Held through back-pressure
      @(negedge clk_i);
    end
    exp_d_q.push_back(r);
    acc_d++;
    @(negedge clk_i);
    dcache_req.valid = 1'b0;
  endtask

  task automatic wait_drain();
    while (exp_i_q.size() != 0 || exp_d_q.size() != 0) @(negedge clk_i);
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_err0 = errors;
    order_q.delete();
  endtask

  task automatic end_test();
    wait_drain();
    n_tests++;
    if (errors == test_err0) n_pass++;
    $display("test %-14s %s", test_name, (errors == test_err0) ? "ok" : "FAILED");
  endtask

  // Both ports busy at once with optional writes on the data port
  task automatic dual_traffic(input int n, input bit writes);
    fork
      for (int k = 0; k < n; k++) send_fetch(ADDR_W'($urandom), ID_W'($urandom));
      for (int k = 0; k < n; k++) send_data(rand_dreq(writes & $urandom, ADDR_W'($urandom), 0, 3));
    join
  endtask

  // Response monitor taking expected values in request order per port
  always @(negedge clk_i) begin : monitor
    ilow_req_t ei;
    dlow_req_t ed;
    int b;
    if (rst_ni && icache_res.valid) begin
      if (exp_i_q.size() == 0) begin
        $display("Fetch response arrived with no request outstanding");
        errors++;
      end else begin
        ei = exp_i_q.pop_front();
        check_val("fetch id", ei.id, icache_res.id);
        check_val("fetch blk", ref_mem[blk_index(ei.addr)], icache_res.blk);
        order_q.push_back(0);
      end
    end
    if (rst_ni && dcache_res.valid) begin
      res_d++;  // Every pulse, expected or not
      if (exp_d_q.size() == 0) begin
        $display("Data response arrived with no request outstanding");
        errors++;
      end else begin
        ed = exp_d_q.pop_front();
        b  = blk_index(ed.addr);
        if (ed.rw) ref_mem[b] = merge_blk(ref_mem[b], ed);  // Lands with its response
        check_val("data id", ed.id, dcache_res.id);
        check_val("data blk", ref_mem[b], dcache_res.data);
        order_q.push_back(1);
      end
    end
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles > MAX_CYCLES) begin
      $display("Timeout after %0d cycles, responses still outstanding", cycles);
      $display("tests failed");
      $finish;
    end
  end

  initial begin
    void'($urandom(32'hcdae));
    rst_ni     = 1'b0;
    icache_req = '0;
    dcache_req = '0;
    foreach (ref_mem[b]) ref_mem[b] = '0;
    repeat (3) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);

    start_test("reset");
    check_val("fetch valid", 1'b0, icache_res.valid);
    check_val("data valid", 1'b0, dcache_res.valid);
    check_val("fetch ready", 1'b1, icache_ready);
    check_val("data ready", 1'b1, dcache_ready);
    for (int k = 0; k < 4; k++) send_fetch(ADDR_W'($urandom), ID_W'(k));
    end_test();

    start_test("write_read");
    foreach (addr_pool[k]) addr_pool[k] = ADDR_W'($urandom);
    foreach (addr_pool[k]) send_data(rand_dreq(1'b1, addr_pool[k], 0, 0));
    wait_drain();
    fork
      foreach (addr_pool[k]) send_fetch(addr_pool[k], ID_W'($urandom));
      foreach (addr_pool[k]) send_data(rand_dreq(1'b0, addr_pool[k], 0, 0));
    join
    end_test();

    start_test("partial_write");
    for (int k = 0; k < 8; k++) begin
      send_data(rand_dreq(1'b1, {addr_pool[k % 4][ADDR_W-1:BOFF], BOFF'($urandom)}, 1, 3));
    end
    wait_drain();
    fork
      foreach (addr_pool[k]) send_fetch(addr_pool[k], ID_W'($urandom));
      foreach (addr_pool[k]) send_data(rand_dreq(1'b0, addr_pool[k], 0, 0));
    join
    end_test();

    start_test("id_order");
    dual_traffic(8, 1'b1);
    end_test();

    start_test("fairness");
    dual_traffic(8, 1'b0);
    wait_drain();
    for (int k = 1; k < order_q.size(); k++) begin
      assert (order_q[k] != order_q[k-1]) else begin
        $display("CHECK FAILED %s response %0d port: expected %0d, actual %0d",
                 test_name, k, 1 - order_q[k-1], order_q[k]);
        errors++;
      end
    end
    end_test();

    start_test("backpressure");
    stalled = 1'b0;
    acc_d   = 0;
    res_d   = 0;
    for (int k = 0; k < 8; k++) send_data(rand_dreq($urandom, addr_pool[k % 4], 0, 3));
    wait_drain();
    repeat (L2_LATENCY + 4) @(negedge clk_i);  // Room for a late duplicate response
    if (!stalled) begin
      $display("Data queue never dropped ready during a burst");
      errors++;
    end
    check_val("response count", acc_d, res_d);
    end_test();

    $display("%0d tests run, %0d passed, %0d failed", n_tests, n_pass, n_tests - n_pass);
    if (errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule : mem_arb_tb

`default_nettype wire

/* hdl/mem_arb_top.sv */
// Memory subsystem top
// Fetch and data queues feeding a round-robin arbiter in front of the L2 store
`timescale 1ns/1ps
`default_nettype none

module mem_arb_top #(
  parameter int unsigned L2_BLOCKS   = mem_cfg_pkg::L2_BLOCKS,
  parameter int unsigned L2_LATENCY  = mem_cfg_pkg::L2_LATENCY,
  parameter int unsigned QUEUE_DEPTH = mem_cfg_pkg::QUEUE_DEPTH
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  mem_if_pkg::ilow_req_t icache_req_i,
  output logic                  icache_ready_o,
  output mem_if_pkg::ilow_res_t icache_res_o,
  input  mem_if_pkg::dlow_req_t dcache_req_i,
  output logic                  dcache_ready_o,
  output mem_if_pkg::dlow_res_t dcache_res_o
);

  import mem_if_pkg::*;

  ilow_req_t iq_head;
  logic      iq_head_valid;
  logic      ipop;
  dlow_req_t dq_head;
  logic      dq_head_valid;
  logic      dpop;
  low_req_t  l2_req;
  low_res_t  l2_res;

  req_queue #(.payload_t(ilow_req_t), .DEPTH(QUEUE_DEPTH)) i_iqueue (
    .clk_i, .rst_ni,
    .push_i      (icache_req_i),
    .ready_o     (icache_ready_o),
    .head_o      (iq_head),
    .head_valid_o(iq_head_valid),
    .pop_i       (ipop)
  );

  req_queue #(.payload_t(dlow_req_t), .DEPTH(QUEUE_DEPTH)) i_dqueue (
    .clk_i, .rst_ni,
    .push_i      (dcache_req_i),
    .ready_o     (dcache_ready_o),
    .head_o      (dq_head),
    .head_valid_o(dq_head_valid),
    .pop_i       (dpop)
  );

  memory_arbiter i_arbiter (
    .clk_i, .rst_ni,
    .ireq_i      (iq_head),
    .ireq_valid_i(iq_head_valid),
    .ipop_o      (ipop),
    .dreq_i      (dq_head),
    .dreq_valid_i(dq_head_valid),
    .dpop_o      (dpop),
    .l2_req_o    (l2_req),
    .l2_res_i    (l2_res),
    .ires_o      (icache_res_o),
    .dres_o      (dcache_res_o)
  );

  l2_block_store #(.BLOCKS(L2_BLOCKS), .LATENCY(L2_LATENCY)) i_l2 (
    .clk_i, .rst_ni,
    .req_i(l2_req),
    .res_o(l2_res)
  );

endmodule : mem_arb_top

`default_nettype wire

/* hdl/memory_arbiter.sv */
// Round-robin arbiter between the fetch and data queues
// Issues one request at a time to L2 and returns the response to its port
`timescale 1ns/1ps
`default_nettype none

module memory_arbiter (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  mem_if_pkg::ilow_req_t ireq_i,
  input  logic                  ireq_valid_i,
  output logic                  ipop_o,
  input  mem_if_pkg::dlow_req_t dreq_i,
  input  logic                  dreq_valid_i,
  output logic                  dpop_o,
  output mem_if_pkg::low_req_t  l2_req_o,
  input  mem_if_pkg::low_res_t  l2_res_i,
  output mem_if_pkg::ilow_res_t ires_o,
  output mem_if_pkg::dlow_res_t dres_o
);

  import mem_cfg_pkg::*;
  import mem_if_pkg::*;

  typedef enum logic [1:0] {
    IDLE,
    ICACHE,
    DCACHE
  } state_e;

  state_e state_q;
  state_e state_d;

  // Request mux, the queue head stays put until its response
  always_comb begin
    if (state_q == DCACHE) begin
      l2_req_o.valid   = dreq_valid_i;
      l2_req_o.addr    = dreq_i.addr;
      l2_req_o.rw      = dreq_i.rw;
      l2_req_o.rw_size = dreq_i.rw_size;
      l2_req_o.data    = dreq_i.data;
      l2_req_o.id      = dreq_i.id;
    end else begin
      l2_req_o.valid   = (state_q == ICACHE) && ireq_valid_i;  // Nothing issued from idle
      l2_req_o.addr    = ireq_i.addr;
      l2_req_o.rw      = 1'b0;     // Fetch only reads
      l2_req_o.rw_size = NO_SIZE;  // Full block
      l2_req_o.data    = '0;
      l2_req_o.id      = ireq_i.id;
    end
  end

  // Response steering, one-cycle pulse on the served port
  assign ires_o.valid = (state_q == ICACHE) && l2_res_i.valid;
  assign ires_o.blk   = l2_res_i.blk;
  assign ires_o.id    = l2_res_i.id;
  assign dres_o.valid = (state_q == DCACHE) && l2_res_i.valid;
  assign dres_o.data  = l2_res_i.blk;
  assign dres_o.id    = l2_res_i.id;

  assign ipop_o = ires_o.valid;  // Retire head on its response
  assign dpop_o = dres_o.valid;

  // Round-robin next state
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE: begin
        if (ireq_valid_i) state_d = ICACHE;  // Fetch first
        else if (dreq_valid_i) state_d = DCACHE;
      end
      ICACHE: begin
        if (l2_res_i.valid) begin
          // Hand over if data waits, else stay and see if more fetches follow
          state_d = dreq_valid_i ? DCACHE : ICACHE;
        end else if (!ireq_valid_i) begin
          state_d = dreq_valid_i ? DCACHE : IDLE;  // Fetch queue drained
        end
      end
      DCACHE: begin
        if (l2_res_i.valid) begin
          state_d = ireq_valid_i ? ICACHE : DCACHE;
        end else if (!dreq_valid_i) begin
          state_d = ireq_valid_i ? ICACHE : IDLE;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) state_q <= IDLE;
    else state_q <= state_d;
  end

endmodule : memory_arbiter

`default_nettype wire

/* hdl/l2_block_store.sv */
// L2 block store model
// Fixed-latency block reads, byte-masked writes applied on the response cycle
`timescale 1ns/1ps
`default_nettype none

module l2_block_store #(
  parameter int unsigned BLOCKS  = mem_cfg_pkg::L2_BLOCKS,
  parameter int unsigned LATENCY = mem_cfg_pkg::L2_LATENCY
) (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  mem_if_pkg::low_req_t req_i,
  output mem_if_pkg::low_res_t res_o
);

  import mem_cfg_pkg::*;
  import mem_if_pkg::*;

  localparam int unsigned BYTES = BLK_SIZE / 8;
  localparam int unsigned BOFF  = $clog2(BYTES);  // Offset bits within a block
  localparam int unsigned IDX_W = (BLOCKS > 1) ? $clog2(BLOCKS) : 1;
  localparam int unsigned CNT_W = $clog2(LATENCY + 1);

  logic [BLK_SIZE-1:0] mem_q [BLOCKS];
  logic [CNT_W-1:0]    cnt_q;      // Cycles left on the current request
  logic                res_valid_q;
  logic [BLK_SIZE-1:0] res_blk_q;
  logic [ID_W-1:0]     res_id_q;
  low_req_t            req_q;      // Accepted request
  logic                accept;
  logic                done;
  logic [IDX_W-1:0]    idx;
  logic [BOFF-1:0]     off;
  logic [BYTES-1:0]    byte_mask;
  logic [BLK_SIZE-1:0] cur_blk;
  logic [BLK_SIZE-1:0] merged_blk;

  // Busy through the response cycle so a held request is not taken twice
  assign accept = req_i.valid && (cnt_q == '0) && !res_valid_q;
  assign done   = (cnt_q == CNT_W'(1));

  assign idx     = IDX_W'(req_q.addr[ADDR_W-1:BOFF] % BLOCKS);
  assign off     = req_q.addr[BOFF-1:0];
  assign cur_blk = mem_q[idx];

  // Lane mask, sub-block sizes aligned down to their natural boundary
  always_comb begin
    case (req_q.rw_size)
      BYTE:    byte_mask = BYTES'(1) << off;
      HALF:    byte_mask = BYTES'(2'b11) << {off[BOFF-1:1], 1'b0};
      WORD:    byte_mask = BYTES'(4'hf) << {off[BOFF-1:2], 2'b00};
      default: byte_mask = '1;  // NO_SIZE
    endcase
  end

  always_comb begin
    for (int i = 0; i < BYTES; i++) begin
      merged_blk[i*8 +: 8] = (req_q.rw && byte_mask[i]) ? req_q.data[i*8 +: 8]
                                                        : cur_blk[i*8 +: 8];
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      cnt_q       <= '0;
      res_valid_q <= 1'b0;
    end else begin
      res_valid_q <= done;  // Single-cycle pulse
      if (accept) cnt_q <= CNT_W'(LATENCY);
      else if (cnt_q != '0) cnt_q <= cnt_q - CNT_W'(1);
    end
  end

  // Store starts out cleared
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      for (int b = 0; b < BLOCKS; b++) mem_q[b] <= '0;
    end else if (done && req_q.rw) begin
      mem_q[idx] <= merged_blk;  // Write lands with the response
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) req_q <= req_i;
    if (done) begin
      res_blk_q <= merged_blk;  // Equals stored block on reads
      res_id_q  <= req_q.id;
    end
  end

  assign res_o.valid = res_valid_q;
  assign res_o.blk   = res_blk_q;
  assign res_o.id    = res_id_q;

endmodule : l2_block_store

`default_nettype wire

/* hdl/req_queue.sv */
// Per-port request queue
// Circular FIFO of pending requests, head held until the arbiter pops it
`timescale 1ns/1ps
`default_nettype none

module req_queue #(
  parameter type         payload_t = mem_if_pkg::ilow_req_t,
  parameter int unsigned DEPTH     = mem_cfg_pkg::QUEUE_DEPTH
) (
  input  logic     clk_i,
  input  logic     rst_ni,
  input  payload_t push_i,
  output logic     ready_o,
  output payload_t head_o,
  output logic     head_valid_o,
  input  logic     pop_i
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  payload_t         mem_q [DEPTH];  // Entry storage
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W-1:0] wr_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             push;
  logic             pop;

  // Wrap at the last entry, DEPTH need not be a power of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + PTR_W'(1);
  endfunction

  assign ready_o      = (count_q != CNT_W'(DEPTH));  // Free entry left
  assign head_valid_o = (count_q != '0);
  assign head_o       = mem_q[rd_ptr_q];
  assign push         = push_i.valid && ready_o;
  assign pop          = pop_i && head_valid_o;  // Ignore pops on empty

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= next_ptr(wr_ptr_q);
      if (pop) rd_ptr_q <= next_ptr(rd_ptr_q);
      case ({push, pop})
        2'b10:   count_q <= count_q + CNT_W'(1);
        2'b01:   count_q <= count_q - CNT_W'(1);
        default: count_q <= count_q;  // Both or neither
      endcase
    end
  end

  // Payload storage
  always_ff @(posedge clk_i) begin
    if (push) mem_q[wr_ptr_q] <= push_i;
  end

endmodule : req_queue

`default_nettype wire

/* hdl/mem_if_pkg.sv */
// Memory subsystem interface types
// Request and response structs for the fetch port, data port and L2 link
`default_nettype none

package mem_if_pkg;

  import mem_cfg_pkg::*;

  // Instruction fetch request, always a full block read
  typedef struct packed {
    logic              valid;
    logic [ADDR_W-1:0] addr;
    logic [ID_W-1:0]   id;
  } ilow_req_t;

  // Data port request
  typedef struct packed {
    logic                valid;
    logic [ADDR_W-1:0]   addr;
    logic                rw;       // 1 is write
    rw_size_e            rw_size;
    logic [BLK_SIZE-1:0] data;     // Sits at its byte lane in the block
    logic [ID_W-1:0]     id;
  } dlow_req_t;

  typedef struct packed {
    logic                valid;
    logic [BLK_SIZE-1:0] blk;
    logic [ID_W-1:0]     id;
  } ilow_res_t;

  typedef struct packed {
    logic                valid;
    logic [BLK_SIZE-1:0] data;  // Block after any write
    logic [ID_W-1:0]     id;
  } dlow_res_t;

  // Arbiter to L2 store
  typedef struct packed {
    logic                valid;
    logic [ADDR_W-1:0]   addr;
    logic                rw;
    rw_size_e            rw_size;
    logic [BLK_SIZE-1:0] data;
    logic [ID_W-1:0]     id;
  } low_req_t;

  typedef struct packed {
    logic                valid;
    logic [BLK_SIZE-1:0] blk;
    logic [ID_W-1:0]     id;
  } low_res_t;

endpackage : mem_if_pkg

`default_nettype wire

/* hdl/mem_cfg_pkg.sv */
// Memory subsystem configuration
// Default sizes and the access-size encoding shared by all blocks
`default_nettype none

package mem_cfg_pkg;

  localparam int unsigned BLK_SIZE    = 128;  // Block width in bits
  localparam int unsigned ADDR_W      = 16;   // Byte address width
  localparam int unsigned ID_W        = 4;    // Request tag width
  localparam int unsigned L2_BLOCKS   = 64;   // Blocks held by the L2 store
  localparam int unsigned L2_LATENCY  = 3;    // Accept edge to response valid
  localparam int unsigned QUEUE_DEPTH = 2;    // Entries per port queue

  // Access size of a data request
  typedef enum logic [1:0] {
    NO_SIZE,  // Whole block
    BYTE,
    HALF,
    WORD
  } rw_size_e;

endpackage : mem_cfg_pkg

`default_nettype wire
